// File: sources.f
rtl/moroso_pkg.sv
rtl/regfile.sv
rtl/lane_decode.sv
rtl/lane_alu.sv
rtl/issue_ctrl.sv
rtl/moroso_rf_top.sv
verification/tb_moroso_rf.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --top-module tb_moroso_rf -f sources.f -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TEST OK$" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: verification/tb_moroso_rf.sv
// Moroso register file testbench
`default_nettype none

module tb_moroso_rf;
   timeunit 1ns;
   timeprecision 1ps;

   import moroso_pkg::*;

   logic             clkrst_core_clk;
   logic             clkrst_core_rst_n;
   logic             bundle_valid;
   bundle_t          bundle;
   wb_bundle_t       wb;
   logic             wb_valid;
   logic [2:0]       preds;

   bundle_t          tbl_bundle [64];
   logic             tbl_valid [64];
   int               tbl_gap [64];
   logic             tbl_chk [64];
   logic [2:0]       tbl_preds [64];
   int               tbl_len = 0;
   int               watchdog_cycles = 0;
   logic             table_ready = 1'b0;
   logic [31:0]      lcg_state = 32'he0c9;
   int               check_count = 0;
   int               error_count = 0;

   // Shadow register state and the model's pipeline stages
   logic [31:0]      sh_reg [num_regs];
   logic [2:0]       sh_preds;
   lane_instr_u      m_ins [num_lanes];
   logic [31:0]      m_a [num_lanes];
   logic [31:0]      m_b [num_lanes];
   logic             m_valid;
   wb_bundle_t       exp_wb;
   logic             exp_valid;

   moroso_rf_top UUT (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .bundle            (bundle),
      .wb                (wb),
      .wb_valid          (wb_valid),
      .preds             (preds)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic lane_instr_u r_instr(opcode_e op, logic [1:0] g, logic [4:0] rd,
                                           logic [4:0] rs, logic [4:0] rt);
      lane_instr_u w;
      w.r_form = '{op, g, rd, rs, rt, 9'd0};
      return w;
   endfunction

   function automatic lane_instr_u i_instr(opcode_e op, logic [1:0] g, logic [4:0] rd,
                                           logic [4:0] rs, logic [13:0] imm);
      lane_instr_u w;
      w.i_form = '{op, g, rd, rs, imm};
      return w;
   endfunction

   function automatic bundle_t mk_bundle(lane_instr_u l0, lane_instr_u l1, lane_instr_u l2,
                                         lane_instr_u l3);
      bundle_t b;
      b.lane[0] = l0;
      b.lane[1] = l1;
      b.lane[2] = l2;
      b.lane[3] = l3;
      return b;
   endfunction

   // Random register-register operation from add through xor
   function automatic lane_instr_u rand_alu(int rd_base, int rd_span, int src_base,
                                            int src_span);
      opcode_e    op;
      logic [4:0] rd;
      logic [4:0] rs;
      logic [4:0] rt;
      op = opcode_e'(6'(1 + (next_rand() >> 16) % 5));
      rd = 5'(rd_base + (next_rand() >> 16) % rd_span);
      rs = 5'(src_base + (next_rand() >> 16) % src_span);
      rt = 5'(src_base + (next_rand() >> 16) % src_span);
      return r_instr(op, guard_always, rd, rs, rt);
   endfunction

   function automatic logic [31:0] model_result(opcode_e op, logic [31:0] a, logic [31:0] b);
      case (op)
         add, addi: return a + b;
         sub:       return a - b;
         and_op:    return a & b;
         or_op:     return a | b;
         xor_op:    return a ^ b;
         cmpeq:     return {31'd0, a == b};
         cmplt:     return {31'd0, $signed(a) < $signed(b)};
         default:   return 32'd0;
      endcase
   endfunction

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("Error %s expected %h got %h", name, expected, actual);
      end
   endtask

   task automatic add_entry(bundle_t b, logic v, int gap, logic chk, logic [2:0] p);
      tbl_bundle[tbl_len] = b;
      tbl_valid[tbl_len] = v;
      tbl_gap[tbl_len] = gap;
      tbl_chk[tbl_len] = chk;
      tbl_preds[tbl_len] = p;
      tbl_len++;
   endtask

   task automatic build_table();
      lane_instr_u nl;
      lane_instr_u ln [num_lanes];
      int          max_gap;
      nl = r_instr(nop, guard_always, 5'd0, 5'd0, 5'd0);
      add_entry(mk_bundle(nl, nl, nl, nl), 1'b1, 3, 1'b0, 3'b000);
      // Back-to-back random immediates into r1 to r16
      for (int k = 0; k < 4; k++) begin
         for (int l = 0; l < num_lanes; l++) begin
            ln[l] = i_instr(addi, guard_always, 5'(4 * k + l + 1), 5'd0, 14'(next_rand() >> 12));
         end
         add_entry(mk_bundle(ln[0], ln[1], ln[2], ln[3]), 1'b1, (k == 3) ? 3 : 1, 1'b0, 3'b000);
      end
      for (int k = 0; k < 8; k++) begin
         for (int l = 0; l < num_lanes; l++) begin
            ln[l] = rand_alu(1, 31, 0, 32);
         end
         add_entry(mk_bundle(ln[0], ln[1], ln[2], ln[3]), 1'b1, 3, 1'b0, 3'b000);
      end
      // r20 is -5 while r21 and r22 are 7
      add_entry(mk_bundle(i_instr(addi, guard_always, 5'd20, 5'd0, 14'h3ffb),
                          i_instr(addi, guard_always, 5'd21, 5'd0, 14'd7),
                          i_instr(addi, guard_always, 5'd22, 5'd0, 14'd7), nl),
                1'b1, 3, 1'b0, 3'b000);
      add_entry(mk_bundle(r_instr(cmplt, guard_always, 5'd0, 5'd20, 5'd21),
                          r_instr(cmpeq, guard_always, 5'd1, 5'd21, 5'd22),
                          r_instr(cmplt, guard_always, 5'd2, 5'd21, 5'd20), nl),
                1'b1, 2, 1'b1, 3'b011);
      add_entry(mk_bundle(i_instr(addi, 2'd0, 5'd23, 5'd0, 14'd100),
                          i_instr(addi, 2'd2, 5'd24, 5'd0, 14'd200),
                          i_instr(addi, 2'd1, 5'd25, 5'd0, 14'd300),
                          i_instr(addi, guard_always, 5'd26, 5'd0, 14'd400)),
                1'b1, 2, 1'b0, 3'b000);
      add_entry(mk_bundle(r_instr(cmpeq, guard_always, 5'd0, 5'd20, 5'd21),
                          r_instr(cmplt, guard_always, 5'd1, 5'd22, 5'd21),
                          r_instr(cmplt, guard_always, 5'd2, 5'd20, 5'd22), nl),
                1'b1, 2, 1'b1, 3'b100);
      add_entry(mk_bundle(i_instr(addi, 2'd0, 5'd23, 5'd0, 14'd101),
                          i_instr(addi, 2'd2, 5'd24, 5'd0, 14'd201),
                          i_instr(addi, 2'd1, 5'd25, 5'd0, 14'd301),
                          i_instr(addi, guard_always, 5'd26, 5'd0, 14'd401)),
                1'b1, 3, 1'b0, 3'b000);
      // Lane 0 beats lane 1 on r27 and lane 2 beats lane 3 on p2
      add_entry(mk_bundle(i_instr(addi, guard_always, 5'd27, 5'd0, 14'd11),
                          i_instr(addi, guard_always, 5'd27, 5'd0, 14'd22),
                          r_instr(cmplt, guard_always, 5'd2, 5'd21, 5'd20),
                          r_instr(cmpeq, guard_always, 5'd2, 5'd21, 5'd22)),
                1'b1, 3, 1'b1, 3'b000);
      add_entry(mk_bundle(r_instr(add, guard_always, 5'd28, 5'd27, 5'd0),
                          i_instr(addi, 2'd2, 5'd29, 5'd0, 14'd5), nl,
                          r_instr(or_op, guard_always, 5'd30, 5'd23, 5'd24)),
                1'b1, 3, 1'b0, 3'b000);
      // Without the valid strobe neither the register nor p0 may change
      add_entry(mk_bundle(i_instr(addi, guard_always, 5'd31, 5'd0, 14'd77),
                          r_instr(cmpeq, guard_always, 5'd0, 5'd21, 5'd22), nl, nl),
                1'b0, 3, 1'b1, 3'b000);
      for (int k = 0; k < 4; k++) begin
         for (int l = 0; l < num_lanes; l++) begin
            ln[l] = rand_alu(17, 15, 1, 16);
         end
         add_entry(mk_bundle(ln[0], ln[1], ln[2], ln[3]), 1'b1, 1, 1'b0, 3'b000);
      end
      add_entry(mk_bundle(nl, nl, nl, nl), 1'b1, 4, 1'b0, 3'b000);
      max_gap = 1;
      for (int i = 0; i < tbl_len; i++) begin
         if (tbl_gap[i] > max_gap) begin
            max_gap = tbl_gap[i];
         end
      end
      watchdog_cycles = tbl_len * max_gap + 40;
   endtask

   // Predicates settle on the fourth falling edge after the bundle is driven
   task automatic check_preds_later(logic [2:0] expected);
      repeat (4) @(negedge clkrst_core_clk);
      check_value("preds", 32'(expected), 32'(preds));
   endtask

   initial begin
      clkrst_core_clk = 1'b0;
      forever #5 clkrst_core_clk = ~clkrst_core_clk;
   end

   // Cycle model of decode, execute and writeback
   always @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      wb_bundle_t nxt_wb;
      logic       nxt_valid;
      opcode_e    op;
      logic [3:0] gmask;
      logic       en;
      if (!clkrst_core_rst_n) begin
         for (int r = 0; r < num_regs; r++) begin
            sh_reg[r] = '0;
         end
         sh_preds = '0;
         m_valid = 1'b0;
         exp_valid = 1'b0;
         exp_wb = '0;
      end else begin
         // Guard value 3 maps to the constant one on top
         nxt_valid = m_valid;
         gmask = {1'b1, sh_preds};
         for (int l = 0; l < num_lanes; l++) begin
            op = m_ins[l].r_form.opcode;
            en = m_valid && gmask[m_ins[l].r_form.guard];
            nxt_wb.lane[l].rd_num = m_ins[l].r_form.rd;
            nxt_wb.lane[l].rd_data = model_result(op, m_a[l], m_b[l]);
            nxt_wb.lane[l].rd_we = en && (op inside {add, sub, and_op, or_op, xor_op, addi});
            nxt_wb.lane[l].pred_we = en && (op inside {cmpeq, cmplt});
         end
         // Operands come from the registers before this edge's writeback
         for (int l = 0; l < num_lanes; l++) begin
            m_ins[l] = bundle.lane[l];
            m_a[l] = sh_reg[m_ins[l].r_form.rs];
            if (m_ins[l].i_form.opcode == addi) begin
               m_b[l] = {{18{m_ins[l].i_form.imm[13]}}, m_ins[l].i_form.imm};
            end else begin
               m_b[l] = sh_reg[m_ins[l].r_form.rt];
            end
         end
         m_valid = bundle_valid;
         // Top lane first so lane 0 leaves the final value
         for (int l = num_lanes - 1; l >= 0; l--) begin
            if (exp_wb.lane[l].rd_we) begin
               sh_reg[exp_wb.lane[l].rd_num] = exp_wb.lane[l].rd_data;
            end
            if (exp_wb.lane[l].pred_we && exp_wb.lane[l].rd_num[1:0] != 2'd3) begin
               sh_preds[exp_wb.lane[l].rd_num[1:0]] = exp_wb.lane[l].rd_data[0];
            end
         end
         exp_wb = nxt_wb;
         exp_valid = nxt_valid;
      end
   end

   always @(negedge clkrst_core_clk) begin
      check_value("wb_valid", 32'(exp_valid), 32'(wb_valid));
      check_value("preds", 32'(sh_preds), 32'(preds));
      for (int l = 0; l < num_lanes; l++) begin
         check_value($sformatf("wb.lane[%0d].rd_we", l), 32'(exp_wb.lane[l].rd_we),
                     32'(wb.lane[l].rd_we));
         check_value($sformatf("wb.lane[%0d].pred_we", l), 32'(exp_wb.lane[l].pred_we),
                     32'(wb.lane[l].pred_we));
         if (exp_wb.lane[l].rd_we || exp_wb.lane[l].pred_we) begin
            check_value($sformatf("wb.lane[%0d].rd_num", l), 32'(exp_wb.lane[l].rd_num),
                        32'(wb.lane[l].rd_num));
            check_value($sformatf("wb.lane[%0d].rd_data", l), exp_wb.lane[l].rd_data,
                        wb.lane[l].rd_data);
         end
      end
   end

   initial begin
      wait (table_ready);
      repeat (watchdog_cycles) @(posedge clkrst_core_clk);
      $display("Watchdog expired before the bundle table was fully applied");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      clkrst_core_rst_n = 1'b0;
      bundle_valid = 1'b0;
      bundle = '0;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(posedge clkrst_core_clk);
      clkrst_core_rst_n <= 1'b1;
      for (int i = 0; i < tbl_len; i++) begin
         @(posedge clkrst_core_clk);
         bundle <= tbl_bundle[i];
         bundle_valid <= tbl_valid[i];
         if (tbl_chk[i]) begin
            fork
               check_preds_later(tbl_preds[i]);
            join_none
         end
         repeat (tbl_gap[i] - 1) begin
            @(posedge clkrst_core_clk);
            bundle <= '0;
            bundle_valid <= 1'b0;
         end
      end
      repeat (4) @(posedge clkrst_core_clk);
      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/moroso_rf_top.sv
// Moroso register file and operand path
`default_nettype none

module moroso_rf_top (
   input  wire logic                         clkrst_core_clk,
   input  wire logic                         clkrst_core_rst_n,
   input  wire logic                         bundle_valid,
   input  wire moroso_pkg::bundle_t          bundle,
   output moroso_pkg::wb_bundle_t            wb,
   output logic                              wb_valid,
   output logic [moroso_pkg::num_preds-1:0]  preds
);

   import moroso_pkg::*;

   logic [num_lanes-1:0][4:0]  rs_num;
   logic [num_lanes-1:0][4:0]  rt_num;
   logic [num_lanes-1:0][31:0] rs_data;
   logic [num_lanes-1:0][31:0] rt_data;
   uop_t [num_lanes-1:0]       uops;
   logic [num_lanes-1:0][31:0] results;

   // The writeback bundle goes to the register file and to the outputs alike
   regfile u_regfile (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .rs_num            (rs_num),
      .rt_num            (rt_num),
      .rs_data           (rs_data),
      .rt_data           (rt_data),
      .wb                (wb),
      .preds             (preds)
   );

   for (genvar l = 0; l < num_lanes; l++) begin : g_lane
      lane_decode u_decode (
         .clkrst_core_clk   (clkrst_core_clk),
         .clkrst_core_rst_n (clkrst_core_rst_n),
         .instr             (bundle.lane[l]),
         .rs_num            (rs_num[l]),
         .rt_num            (rt_num[l]),
         .rs_data           (rs_data[l]),
         .rt_data           (rt_data[l]),
         .uop               (uops[l])
      );

      lane_alu u_alu (
         .uop    (uops[l]),
         .result (results[l])
      );
   end

   issue_ctrl u_issue_ctrl (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .bundle_valid      (bundle_valid),
      .uops              (uops),
      .results           (results),
      .preds             (preds),
      .wb                (wb),
      .wb_valid          (wb_valid)
   );

endmodule

`default_nettype wire

// File: rtl/issue_ctrl.sv
// Issue and writeback control
`default_nettype none

module issue_ctrl (
   input  wire logic                                   clkrst_core_clk,
   input  wire logic                                   clkrst_core_rst_n,
   input  wire logic                                   bundle_valid,
   input  wire moroso_pkg::uop_t [moroso_pkg::num_lanes-1:0] uops,
   input  wire logic [moroso_pkg::num_lanes-1:0][31:0] results,
   input  wire logic [moroso_pkg::num_preds-1:0]       preds,
   output moroso_pkg::wb_bundle_t                      wb,
   output logic                                        wb_valid
);

   import moroso_pkg::*;

   logic                 s1_valid;
   logic [num_lanes-1:0] lane_en;
   wb_bundle_t           wb_next;

   // Guards read the predicates as they stand in the execute cycle
   always_comb begin
      for (int l = 0; l < num_lanes; l++) begin
         if (uops[l].guard == guard_always) begin
            lane_en[l] = s1_valid;
         end else begin
            lane_en[l] = s1_valid & preds[uops[l].guard];
         end
      end
   end

   always_comb begin
      for (int l = 0; l < num_lanes; l++) begin
         wb_next.lane[l].rd_num = uops[l].rd;
         wb_next.lane[l].rd_data = results[l];
         wb_next.lane[l].rd_we = lane_en[l] & uops[l].reg_we;
         wb_next.lane[l].pred_we = lane_en[l] & uops[l].pred_we;
      end
   end

   // Stage 1 valid is captured at the same edge as the decoded micro-ops
   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= bundle_valid;
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         wb <= '0;
         wb_valid <= 1'b0;
      end else begin
         wb <= wb_next;
         wb_valid <= s1_valid;
      end
   end

endmodule

`default_nettype wire

// File: rtl/lane_alu.sv
// Lane integer ALU
`default_nettype none

module lane_alu (
   input  wire moroso_pkg::uop_t uop,
   output logic [31:0]           result
);

   import moroso_pkg::*;

   always_comb begin
      case (uop.op)
         add: begin
            result = uop.a + uop.b;
         end
         addi: begin
            // Operand b already holds the sign-extended immediate
            result = uop.a + uop.b;
         end
         sub: begin
            result = uop.a - uop.b;
         end
         and_op: begin
            result = uop.a & uop.b;
         end
         or_op: begin
            result = uop.a | uop.b;
         end
         xor_op: begin
            result = uop.a ^ uop.b;
         end
         cmpeq: begin
            result = {31'b0, (uop.a == uop.b)};
         end
         cmplt: begin
            // Compare as two's complement values
            result = {31'b0, ($signed(uop.a) < $signed(uop.b))};
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/lane_decode.sv
// Lane instruction decoder
`default_nettype none

module lane_decode (
   input  wire logic                    clkrst_core_clk,
   input  wire logic                    clkrst_core_rst_n,
   input  wire moroso_pkg::lane_instr_u instr,
   output logic [4:0]                   rs_num,
   output logic [4:0]                   rt_num,
   input  wire logic [31:0]             rs_data,
   input  wire logic [31:0]             rt_data,
   output moroso_pkg::uop_t             uop
);

   import moroso_pkg::*;

   uop_t uop_next;

   // The rs field lies at the same place in both views
   assign rs_num = instr.r_form.rs;
   // For i_form this reads a register picked by immediate bits, and the data is not used
   assign rt_num = instr.r_form.rt;

   always_comb begin
      uop_next = '0;
      uop_next.op = instr.r_form.opcode;
      uop_next.guard = instr.r_form.guard;
      uop_next.rd = instr.r_form.rd;
      uop_next.a = rs_data;
      if (instr.r_form.opcode == addi) begin
         uop_next.b = {{18{instr.i_form.imm[13]}}, instr.i_form.imm};
      end else begin
         uop_next.b = rt_data;
      end
      case (instr.r_form.opcode)
         add, sub, and_op, or_op, xor_op, addi: begin
            uop_next.reg_we = 1'b1;
         end
         cmpeq, cmplt: begin
            uop_next.pred_we = 1'b1;
         end
         default: begin
            // Unknown encodings behave as nop
            uop_next.op = nop;
         end
      endcase
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         uop <= '0;
      end else begin
         uop <= uop_next;
      end
   end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
// Multi-port register file
`default_nettype none

module regfile (
   input  wire logic                                        clkrst_core_clk,
   input  wire logic                                        clkrst_core_rst_n,
   input  wire logic [moroso_pkg::num_lanes-1:0][4:0]       rs_num,
   input  wire logic [moroso_pkg::num_lanes-1:0][4:0]       rt_num,
   output logic      [moroso_pkg::num_lanes-1:0][31:0]      rs_data,
   output logic      [moroso_pkg::num_lanes-1:0][31:0]      rt_data,
   input  wire moroso_pkg::wb_bundle_t                      wb,
   output logic      [moroso_pkg::num_preds-1:0]            preds
);

   import moroso_pkg::*;

   logic [31:0] mem [num_regs];

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int r = 0; r < num_regs; r++) begin
            mem[r] <= '0;
         end
         preds <= '0;
      end else begin
         // Walk from the top lane down so the lowest lane is applied last and wins
         for (int l = num_lanes - 1; l >= 0; l--) begin
            if (wb.lane[l].rd_we) begin
               mem[wb.lane[l].rd_num] <= wb.lane[l].rd_data;
            end
            // Predicate number 3 does not exist and is dropped
            if (wb.lane[l].pred_we && (int'(wb.lane[l].rd_num[1:0]) < num_preds)) begin
               preds[wb.lane[l].rd_num[1:0]] <= wb.lane[l].rd_data[0];
            end
         end
      end
   end

   // Reads are combinational, so a write shows up one cycle after the edge
   always_comb begin
      for (int l = 0; l < num_lanes; l++) begin
         rs_data[l] = mem[rs_num[l]];
         rt_data[l] = mem[rt_num[l]];
      end
   end

endmodule

`default_nettype wire

// File: rtl/moroso_pkg.sv
// Moroso VLIW shared types
`default_nettype none

package moroso_pkg;

   localparam int num_lanes = 4;
   localparam int num_regs = 32;
   localparam int num_preds = 3;

   // Guard value that ignores the predicates
   localparam logic [1:0] guard_always = 2'd3;

   typedef enum logic [5:0] {
      nop    = 6'd0,
      add    = 6'd1,
      sub    = 6'd2,
      and_op = 6'd3,
      or_op  = 6'd4,
      xor_op = 6'd5,
      addi   = 6'd6,
      cmpeq  = 6'd7,
      cmplt  = 6'd8
   } opcode_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [1:0] guard;
      logic [4:0] rd;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [8:0] pad;
   } r_form_t;

   typedef struct packed {
      opcode_e     opcode;
      logic [1:0]  guard;
      logic [4:0]  rd;
      logic [4:0]  rs;
      logic [13:0] imm;
   } i_form_t;

   // The opcode sits in the same bits of both views and selects between them
   typedef union packed {
      r_form_t r_form;
      i_form_t i_form;
   } lane_instr_u;

   // Lane 0 occupies the low word
   typedef struct packed {
      lane_instr_u [num_lanes-1:0] lane;
   } bundle_t;

   typedef struct packed {
      opcode_e     op;
      logic [1:0]  guard;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic        reg_we;
      logic        pred_we;
   } uop_t;

   // For a predicate write rd_num[1:0] picks the predicate and rd_data[0] is its value
   typedef struct packed {
      logic [4:0]  rd_num;
      logic [31:0] rd_data;
      logic        rd_we;
      logic        pred_we;
   } wb_lane_t;

   typedef struct packed {
      wb_lane_t [num_lanes-1:0] lane;
   } wb_bundle_t;

endpackage

`default_nettype wire
